// File: hdl/dma_pkg.sv
// DMA control front end shared definitions
// Register map, field widths, enums and the command structs used by the
// decoder, the command queues and the transfer ID allocator
package dma_pkg;

   // ******************************
   // Sizes
   // ******************************
   localparam int NB_TRANSFERS    = 4;
   localparam int SID_WIDTH       = 2;
   localparam int LEN_WIDTH       = 16;
   localparam int TCDM_ADD_WIDTH  = 16;
   localparam int EXT_ADD_WIDTH   = 32;
   localparam int CMD_QUEUE_DEPTH = 2;

   // ******************************
   // Register map
   // ******************************
   // Word offset sits in bits 3:2 of the control address
   localparam int REG_SEL_LSB   = 2;
   localparam int REG_SEL_WIDTH = 2;

   localparam logic [REG_SEL_WIDTH-1:0] REG_CMD    = 2'd0;
   localparam logic [REG_SEL_WIDTH-1:0] REG_TCDM   = 2'd1;
   localparam logic [REG_SEL_WIDTH-1:0] REG_EXT    = 2'd2;
   localparam logic [REG_SEL_WIDTH-1:0] REG_STATUS = 2'd3;

   // Command word and status word bit positions
   localparam int CMD_OPC_BIT = 16;
   localparam int CMD_INC_BIT = 17;
   localparam int DONE_LSB    = 16;

   typedef enum logic {
      OPC_TX = 1'b0,   // local to external
      OPC_RX = 1'b1    // external to local
   } dma_opc_e;

   typedef enum logic {
      DEC_IDLE = 1'b0,
      DEC_RESP = 1'b1
   } dec_state_e;

   typedef struct packed {
      logic        wen;
      logic [3:0]  be;
      logic [31:0] add;
      logic [31:0] wdata;
   } ctrl_req_t;

   typedef struct packed {
      logic        gnt;
      logic        r_valid;
      logic [31:0] r_data;
   } ctrl_rsp_t;

   typedef struct packed {
      logic [LEN_WIDTH-1:0] len;
      dma_opc_e             opc;
      logic                 inc;
      logic [SID_WIDTH-1:0] sid;
   } cmd_word_t;

   typedef struct packed {
      cmd_word_t                 cmd;
      logic [TCDM_ADD_WIDTH-1:0] tcdm_add;
      logic [EXT_ADD_WIDTH-1:0]  ext_add;
   } dma_cmd_t;

endpackage

// File: hdl/dma_cmd_fifo.sv
// Command queue
// Small synchronous FIFO, circular buffer plus occupancy counter,
// head entry shown on the output without a pop
`timescale 1ns/1ns

module dma_cmd_fifo #(
   parameter int WIDTH = 8,
   parameter int DEPTH = 2
) (
   input  logic             clk_i,
   input  logic             rst_n_i,
   input  logic             push_i,
   input  logic [WIDTH-1:0] push_data_i,
   input  logic             pop_i,
   output logic [WIDTH-1:0] pop_data_o,
   output logic             full_o,
   output logic             empty_o
);

   typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
   typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

   logic [WIDTH-1:0] mem_q [DEPTH];
   ptr_t             wr_ptr_q;
   ptr_t             rd_ptr_q;
   cnt_t             count_q;

   assign pop_data_o = mem_q[rd_ptr_q];
   assign full_o     = (count_q == cnt_t'(DEPTH));
   assign empty_o    = (count_q == '0);

   // Pointers and occupancy
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push_i) begin
            wr_ptr_q <= (wr_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (pop_i) begin
            rd_ptr_q <= (rd_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         end
         if (push_i && !pop_i) begin
            count_q <= count_q + 1'b1;
         end else if (pop_i && !push_i) begin
            count_q <= count_q - 1'b1;
         end
      end
   end

   // Storage
   always_ff @(posedge clk_i) begin
      if (push_i) begin
         mem_q[wr_ptr_q] <= push_data_i;
      end
   end

   a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      push_i |-> !full_o);

   a_no_pop_empty : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      pop_i |-> !empty_o);

endmodule

// File: hdl/dma_sid_alloc.sv
// Transfer ID allocator
// Hands out the lowest free ID, keeps the allocated and done bitmaps and
// clears both on a free pulse from the core
`timescale 1ns/1ns

module dma_sid_alloc import dma_pkg::*; (
   input  logic                    clk_i,
   input  logic                    rst_n_i,
   input  logic                    alloc_req_i,
   input  logic [NB_TRANSFERS-1:0] free_mask_i,
   input  logic                    done_valid_i,
   input  logic [SID_WIDTH-1:0]    done_sid_i,
   output logic                    alloc_gnt_o,
   output logic [SID_WIDTH-1:0]    alloc_sid_o,
   output logic [NB_TRANSFERS-1:0] alloc_map_o,
   output logic [NB_TRANSFERS-1:0] done_map_o
);

   logic [NB_TRANSFERS-1:0] alloc_map_q;
   logic [NB_TRANSFERS-1:0] done_map_q;
   logic [NB_TRANSFERS-1:0] alloc_set;
   logic [NB_TRANSFERS-1:0] done_set;
   logic                    free_found;
   logic [SID_WIDTH-1:0]    free_sid;

   // Priority search, lowest free ID wins
   always_comb begin
      free_found = 1'b0;
      free_sid   = '0;
      for (int i = NB_TRANSFERS - 1; i >= 0; i--) begin
         if (!alloc_map_q[i]) begin
            free_found = 1'b1;
            free_sid   = SID_WIDTH'(i);
         end
      end
   end

   assign alloc_gnt_o = alloc_req_i & free_found;
   assign alloc_sid_o = free_sid;

   assign alloc_set = alloc_gnt_o ? (NB_TRANSFERS'(1) << free_sid) : '0;
   // Reports for IDs that are not allocated are dropped here
   assign done_set  = done_valid_i ? ((NB_TRANSFERS'(1) << done_sid_i) & alloc_map_q) : '0;

   // Free has priority over a done report in the same cycle
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         alloc_map_q <= '0;
         done_map_q  <= '0;
      end else begin
         alloc_map_q <= (alloc_map_q | alloc_set) & ~free_mask_i;
         done_map_q  <= (done_map_q | done_set) & ~free_mask_i;
      end
   end

   assign alloc_map_o = alloc_map_q;
   assign done_map_o  = done_map_q;

   a_gnt_was_free : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      alloc_gnt_o |=> $past(!alloc_map_q[alloc_sid_o]) && alloc_map_q[$past(alloc_sid_o)]);

endmodule

// File: hdl/dma_reg_decoder.sv
// Control target register block
// Decodes core accesses, answers reads one cycle after grant, builds
// command words tagged with the last allocated ID and drives alloc/free
`timescale 1ns/1ns

module dma_reg_decoder import dma_pkg::*; (
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   // Control target
   input  logic                      ctrl_req_valid_i,
   input  ctrl_req_t                 ctrl_req_i,
   output ctrl_rsp_t                 ctrl_rsp_o,
   // ID allocator
   output logic                      alloc_req_o,
   input  logic                      alloc_gnt_i,
   input  logic [SID_WIDTH-1:0]      alloc_sid_i,
   output logic [NB_TRANSFERS-1:0]   free_mask_o,
   input  logic [NB_TRANSFERS-1:0]   alloc_map_i,
   input  logic [NB_TRANSFERS-1:0]   done_map_i,
   // Command queues
   input  logic                      cmd_full_i,
   output logic                      cmd_push_o,
   output cmd_word_t                 cmd_word_o,
   input  logic                      tcdm_full_i,
   output logic                      tcdm_push_o,
   output logic [TCDM_ADD_WIDTH-1:0] tcdm_add_o,
   input  logic                      ext_full_i,
   output logic                      ext_push_o,
   output logic [EXT_ADD_WIDTH-1:0]  ext_add_o
);

   logic [REG_SEL_WIDTH-1:0] reg_sel;
   logic                     gnt;
   logic                     rd_gnt;
   logic [31:0]              status_word;
   logic [31:0]              rd_data_d;
   logic [31:0]              rd_data_q;
   logic [SID_WIDTH-1:0]     sid_q;
   dec_state_e               state_d;
   dec_state_e               state_q;

   assign reg_sel = ctrl_req_i.add[REG_SEL_LSB +: REG_SEL_WIDTH];

   // Status layout
   always_comb begin
      status_word = '0;
      status_word[NB_TRANSFERS-1:0]           = alloc_map_i;
      status_word[DONE_LSB +: NB_TRANSFERS]   = done_map_i;
   end

   // ******************************
   // Access decode and grant
   // ******************************
   always_comb begin
      gnt         = 1'b0;
      alloc_req_o = 1'b0;
      free_mask_o = '0;
      cmd_push_o  = 1'b0;
      tcdm_push_o = 1'b0;
      ext_push_o  = 1'b0;
      rd_data_d   = '0;
      if (ctrl_req_valid_i) begin
         case (reg_sel)
            REG_CMD: begin
               if (ctrl_req_i.wen) begin
                  gnt        = !cmd_full_i;
                  cmd_push_o = !cmd_full_i;
               end else begin
                  // Read asks the allocator for a fresh ID
                  alloc_req_o = 1'b1;
                  gnt         = alloc_gnt_i;
                  rd_data_d   = {{(32 - SID_WIDTH){1'b0}}, alloc_sid_i};
               end
            end
            REG_TCDM: begin
               if (ctrl_req_i.wen) begin
                  gnt         = !tcdm_full_i;
                  tcdm_push_o = !tcdm_full_i;
               end else begin
                  gnt = 1'b1;
               end
            end
            REG_EXT: begin
               if (ctrl_req_i.wen) begin
                  gnt        = !ext_full_i;
                  ext_push_o = !ext_full_i;
               end else begin
                  gnt = 1'b1;
               end
            end
            default: begin
               gnt = 1'b1;
               if (ctrl_req_i.wen) begin
                  free_mask_o = ctrl_req_i.wdata[NB_TRANSFERS-1:0];
               end else begin
                  rd_data_d = status_word;
               end
            end
         endcase
      end
   end

   assign rd_gnt = ctrl_req_valid_i & ~ctrl_req_i.wen & gnt;

   // Payload for the queues
   always_comb begin
      cmd_word_o.len = ctrl_req_i.wdata[LEN_WIDTH-1:0];
      cmd_word_o.opc = dma_opc_e'(ctrl_req_i.wdata[CMD_OPC_BIT]);
      cmd_word_o.inc = ctrl_req_i.wdata[CMD_INC_BIT];
      cmd_word_o.sid = sid_q;
   end

   assign tcdm_add_o = ctrl_req_i.wdata[TCDM_ADD_WIDTH-1:0];
   assign ext_add_o  = ctrl_req_i.wdata[EXT_ADD_WIDTH-1:0];

   // ******************************
   // Read response
   // ******************************
   assign state_d = rd_gnt ? DEC_RESP : DEC_IDLE;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= DEC_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // Read data and the ID handed out by the last REG_CMD read
   always_ff @(posedge clk_i) begin
      if (rd_gnt) begin
         rd_data_q <= rd_data_d;
      end
      if (alloc_req_o && alloc_gnt_i) begin
         sid_q <= alloc_sid_i;
      end
   end

   assign ctrl_rsp_o.gnt     = gnt;
   assign ctrl_rsp_o.r_valid = (state_q == DEC_RESP);
   assign ctrl_rsp_o.r_data  = rd_data_q;

   a_rvalid_after_read : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (ctrl_req_valid_i && ctrl_rsp_o.gnt && !ctrl_req_i.wen) |=> ctrl_rsp_o.r_valid);

   a_rvalid_only_read : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      ctrl_rsp_o.r_valid |-> $past(ctrl_req_valid_i && ctrl_rsp_o.gnt && !ctrl_req_i.wen));

endmodule

// File: hdl/dma_core_if.sv
// Core side interface of the DMA controller
// Register decoder feeding three command queues, joined into one
// outgoing command with a busy level for the cluster
`timescale 1ns/1ns

module dma_core_if import dma_pkg::*; (
   input  logic                    clk_i,
   input  logic                    rst_n_i,
   input  logic                    ctrl_req_valid_i,
   input  ctrl_req_t               ctrl_req_i,
   output ctrl_rsp_t               ctrl_rsp_o,
   output logic                    cmd_req_o,
   output dma_cmd_t                cmd_o,
   input  logic                    cmd_gnt_i,
   output logic                    alloc_req_o,
   input  logic                    alloc_gnt_i,
   input  logic [SID_WIDTH-1:0]    alloc_sid_i,
   output logic [NB_TRANSFERS-1:0] free_mask_o,
   input  logic [NB_TRANSFERS-1:0] alloc_map_i,
   input  logic [NB_TRANSFERS-1:0] done_map_i,
   output logic                    busy_o
);

   logic                      cmd_push;
   logic                      cmd_full;
   logic                      cmd_empty;
   cmd_word_t                 cmd_word;
   cmd_word_t                 cmd_head;
   logic                      tcdm_push;
   logic                      tcdm_full;
   logic                      tcdm_empty;
   logic [TCDM_ADD_WIDTH-1:0] tcdm_add;
   logic [TCDM_ADD_WIDTH-1:0] tcdm_head;
   logic                      ext_push;
   logic                      ext_full;
   logic                      ext_empty;
   logic [EXT_ADD_WIDTH-1:0]  ext_add;
   logic [EXT_ADD_WIDTH-1:0]  ext_head;
   logic                      cmd_pop;

   dma_reg_decoder u_decoder (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .ctrl_req_valid_i (ctrl_req_valid_i),
      .ctrl_req_i       (ctrl_req_i),
      .ctrl_rsp_o       (ctrl_rsp_o),
      .alloc_req_o      (alloc_req_o),
      .alloc_gnt_i      (alloc_gnt_i),
      .alloc_sid_i      (alloc_sid_i),
      .free_mask_o      (free_mask_o),
      .alloc_map_i      (alloc_map_i),
      .done_map_i       (done_map_i),
      .cmd_full_i       (cmd_full),
      .cmd_push_o       (cmd_push),
      .cmd_word_o       (cmd_word),
      .tcdm_full_i      (tcdm_full),
      .tcdm_push_o      (tcdm_push),
      .tcdm_add_o       (tcdm_add),
      .ext_full_i       (ext_full),
      .ext_push_o       (ext_push),
      .ext_add_o        (ext_add)
   );

   // ******************************
   // Command queues
   // ******************************
   dma_cmd_fifo #(.WIDTH($bits(cmd_word_t)), .DEPTH(CMD_QUEUE_DEPTH)) u_cmd_fifo (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .push_i      (cmd_push),
      .push_data_i (cmd_word),
      .pop_i       (cmd_pop),
      .pop_data_o  (cmd_head),
      .full_o      (cmd_full),
      .empty_o     (cmd_empty)
   );

   dma_cmd_fifo #(.WIDTH(TCDM_ADD_WIDTH), .DEPTH(CMD_QUEUE_DEPTH)) u_tcdm_fifo (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .push_i      (tcdm_push),
      .push_data_i (tcdm_add),
      .pop_i       (cmd_pop),
      .pop_data_o  (tcdm_head),
      .full_o      (tcdm_full),
      .empty_o     (tcdm_empty)
   );

   dma_cmd_fifo #(.WIDTH(EXT_ADD_WIDTH), .DEPTH(CMD_QUEUE_DEPTH)) u_ext_fifo (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .push_i      (ext_push),
      .push_data_i (ext_add),
      .pop_i       (cmd_pop),
      .pop_data_o  (ext_head),
      .full_o      (ext_full),
      .empty_o     (ext_empty)
   );

   // Command is ready once every queue holds its part
   assign cmd_req_o = !cmd_empty && !tcdm_empty && !ext_empty;
   assign cmd_pop   = cmd_req_o && cmd_gnt_i;

   assign cmd_o.cmd      = cmd_head;
   assign cmd_o.tcdm_add = tcdm_head;
   assign cmd_o.ext_add  = ext_head;

   assign busy_o = (|alloc_map_i) || !cmd_empty || !tcdm_empty || !ext_empty;

endmodule

// File: hdl/dma_ctrl_top.sv
// DMA control front end top level
// Core interface plus transfer ID allocator
`timescale 1ns/1ns

module dma_ctrl_top import dma_pkg::*; (
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   input  logic                 ctrl_req_valid_i,
   input  ctrl_req_t            ctrl_req_i,
   output ctrl_rsp_t            ctrl_rsp_o,
   output logic                 cmd_req_o,
   output dma_cmd_t             cmd_o,
   input  logic                 cmd_gnt_i,
   input  logic                 done_valid_i,
   input  logic [SID_WIDTH-1:0] done_sid_i,
   output logic                 busy_o
);

   logic                    alloc_req;
   logic                    alloc_gnt;
   logic [SID_WIDTH-1:0]    alloc_sid;
   logic [NB_TRANSFERS-1:0] free_mask;
   logic [NB_TRANSFERS-1:0] alloc_map;
   logic [NB_TRANSFERS-1:0] done_map;

   dma_core_if u_core_if (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .ctrl_req_valid_i (ctrl_req_valid_i),
      .ctrl_req_i       (ctrl_req_i),
      .ctrl_rsp_o       (ctrl_rsp_o),
      .cmd_req_o        (cmd_req_o),
      .cmd_o            (cmd_o),
      .cmd_gnt_i        (cmd_gnt_i),
      .alloc_req_o      (alloc_req),
      .alloc_gnt_i      (alloc_gnt),
      .alloc_sid_i      (alloc_sid),
      .free_mask_o      (free_mask),
      .alloc_map_i      (alloc_map),
      .done_map_i       (done_map),
      .busy_o           (busy_o)
   );

   // Completions from the engine sync side land here
   dma_sid_alloc u_sid_alloc (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .alloc_req_i  (alloc_req),
      .free_mask_i  (free_mask),
      .done_valid_i (done_valid_i),
      .done_sid_i   (done_sid_i),
      .alloc_gnt_o  (alloc_gnt),
      .alloc_sid_o  (alloc_sid),
      .alloc_map_o  (alloc_map),
      .done_map_o   (done_map)
   );

endmodule

// File: tb/dma_ref_model.svh
// DMA control front end reference model
// Tracks the allocated and done ID bitmaps, the last handed out ID and
// the contents of the command, TCDM address and external address queues
`ifndef DMA_REF_MODEL_SVH
`define DMA_REF_MODEL_SVH

logic [NB_TRANSFERS-1:0]   m_alloc;
logic [NB_TRANSFERS-1:0]   m_done;
logic [SID_WIDTH-1:0]      m_sid;
cmd_word_t                 m_cmd_q[$];
logic [TCDM_ADD_WIDTH-1:0] m_tcdm_q[$];
logic [EXT_ADD_WIDTH-1:0]  m_ext_q[$];

function automatic void model_reset();
   m_alloc = '0;
   m_done  = '0;
   m_sid   = '0;
   m_cmd_q.delete();
   m_tcdm_q.delete();
   m_ext_q.delete();
endfunction

function automatic logic [SID_WIDTH-1:0] lowest_free_id();
   for (int i = 0; i < NB_TRANSFERS; i++) begin
      if (!m_alloc[i]) begin
         return SID_WIDTH'(i);
      end
   end
   return '0;
endfunction

// Grant expected for an access to register sel
function automatic logic model_gnt(input logic wen, input logic [1:0] sel);
   case (sel)
      REG_CMD:  return wen ? (m_cmd_q.size() < CMD_QUEUE_DEPTH) : (m_alloc != '1);
      REG_TCDM: return wen ? (m_tcdm_q.size() < CMD_QUEUE_DEPTH) : 1'b1;
      REG_EXT:  return wen ? (m_ext_q.size() < CMD_QUEUE_DEPTH) : 1'b1;
      default:  return 1'b1;
   endcase
endfunction

function automatic logic model_cmd_ready();
   return (m_cmd_q.size() != 0) && (m_tcdm_q.size() != 0) && (m_ext_q.size() != 0);
endfunction

function automatic logic model_busy();
   return (m_alloc != '0) || (m_cmd_q.size() != 0) || (m_tcdm_q.size() != 0) ||
          (m_ext_q.size() != 0);
endfunction

// Allocated map in the low half, done map from bit 16
function automatic logic [31:0] model_status();
   return {{(16 - NB_TRANSFERS){1'b0}}, m_done, {(16 - NB_TRANSFERS){1'b0}}, m_alloc};
endfunction

function automatic dma_cmd_t model_head();
   dma_cmd_t c;
   c.cmd      = m_cmd_q[0];
   c.tcdm_add = m_tcdm_q[0];
   c.ext_add  = m_ext_q[0];
   return c;
endfunction

// State after the coming clock edge
function automatic void model_edge(input logic acc, input logic wen, input logic [1:0] sel,
                                   input logic [31:0] wdata, input logic dv,
                                   input logic [SID_WIDTH-1:0] dsid, input logic pop);
   logic [NB_TRANSFERS-1:0] set_alloc;
   logic [NB_TRANSFERS-1:0] set_done;
   logic [NB_TRANSFERS-1:0] clr;
   cmd_word_t               w;
   set_alloc = '0;
   set_done  = '0;
   clr       = '0;
   if (pop) begin
      void'(m_cmd_q.pop_front());
      void'(m_tcdm_q.pop_front());
      void'(m_ext_q.pop_front());
   end
   // Completions only count for allocated IDs
   if (dv && m_alloc[dsid]) begin
      set_done[dsid] = 1'b1;
   end
   if (acc) begin
      case (sel)
         REG_CMD: begin
            if (wen) begin
               w.len = wdata[15:0];
               w.opc = dma_opc_e'(wdata[16]);
               w.inc = wdata[17];
               w.sid = m_sid;
               m_cmd_q.push_back(w);
            end else begin
               m_sid = lowest_free_id();
               set_alloc[m_sid] = 1'b1;
            end
         end
         REG_TCDM: if (wen) m_tcdm_q.push_back(wdata[TCDM_ADD_WIDTH-1:0]);
         REG_EXT:  if (wen) m_ext_q.push_back(wdata);
         default:  if (wen) clr = wdata[NB_TRANSFERS-1:0];
      endcase
   end
   m_alloc = (m_alloc | set_alloc) & ~clr;
   m_done  = (m_done | set_done) & ~clr;
endfunction

`endif

// File: tb/dma_ctrl_tb.sv
// DMA control front end testbench
// Random transfers from a fixed seed against a reference model of the
// ID bitmaps and the command queues, with random engine back-pressure
`timescale 1ns/1ns

module dma_ctrl_tb import dma_pkg::*; ();

   localparam int SEED       = 21;
   localparam int NB_TESTS   = 150;
   // Generous margin over the worst case stall per transfer
   localparam int MAX_CYCLES = NB_TESTS * 120 + 2000;

   logic                 clk;
   logic                 rst_n;
   logic                 ctrl_valid;
   ctrl_req_t            ctrl_req;
   ctrl_rsp_t            ctrl_rsp;
   logic                 cmd_req;
   dma_cmd_t             cmd;
   logic                 cmd_gnt;
   logic                 done_valid;
   logic [SID_WIDTH-1:0] done_sid;
   logic                 busy;

   logic                 exp_rvalid;
   logic [31:0]          exp_rdata;
   logic                 granted;
   int                   cycle_cnt;

   `include "dma_ref_model.svh"

   dma_ctrl_top UUT (
      .clk_i            (clk),
      .rst_n_i          (rst_n),
      .ctrl_req_valid_i (ctrl_valid),
      .ctrl_req_i       (ctrl_req),
      .ctrl_rsp_o       (ctrl_rsp),
      .cmd_req_o        (cmd_req),
      .cmd_o            (cmd),
      .cmd_gnt_i        (cmd_gnt),
      .done_valid_i     (done_valid),
      .done_sid_i       (done_sid),
      .busy_o           (busy)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("Mismatch at %0t: %s, got %0h expected %0h", $time, what, actual, expected);
         $display("Simulation FAILED");
         $fatal(1, "Check failed");
      end
   endtask

   // ******************************
   // One clock cycle
   // ******************************
   // Outputs are checked at the falling edge, the model steps past the
   // rising edge, then engine side inputs change 2 ns later
   task automatic run_cycle();
      logic [1:0] sel;
      logic       exp_gnt;
      logic       pop;
      @(negedge clk);
      cycle_cnt++;
      if (cycle_cnt > MAX_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         $display("Simulation FAILED");
         $fatal(1, "Timeout");
      end
      sel = ctrl_req.add[3:2];
      check_value(ctrl_rsp.r_valid, exp_rvalid, "r_valid");
      if (exp_rvalid) begin
         check_value(ctrl_rsp.r_data, exp_rdata, "read data");
      end
      check_value(busy, model_busy(), "busy_o");
      check_value(cmd_req, model_cmd_ready(), "cmd_req_o");
      pop = cmd_req && cmd_gnt;
      if (pop) begin
         check_value(cmd, model_head(), "outgoing command");
      end
      exp_gnt = model_gnt(ctrl_req.wen, sel);
      if (ctrl_valid) begin
         check_value(ctrl_rsp.gnt, exp_gnt, "gnt");
      end
      granted    = ctrl_valid && exp_gnt;
      exp_rvalid = granted && !ctrl_req.wen;
      if (exp_rvalid) begin
         exp_rdata = (sel == REG_CMD) ? 32'(lowest_free_id()) : model_status();
      end
      model_edge(granted, ctrl_req.wen, sel, ctrl_req.wdata, done_valid, done_sid, pop);
      @(posedge clk);
      #2;
      cmd_gnt    = ($urandom % 5) < 2;
      done_valid = ($urandom % 4) == 0;
      done_sid   = SID_WIDTH'($urandom % NB_TRANSFERS);
   endtask

   task automatic drive_req(input logic wen, input logic [1:0] sel, input logic [31:0] wdata);
      ctrl_valid     = 1'b1;
      ctrl_req.wen   = wen;
      ctrl_req.be    = 4'hF;
      ctrl_req.add   = {28'h0, sel, 2'b00};
      ctrl_req.wdata = wdata;
   endtask

   // Hold the access until it is granted
   task automatic reg_access(input logic wen, input logic [1:0] sel, input logic [31:0] wdata);
      drive_req(wen, sel, wdata);
      granted = 1'b0;
      while (!granted) begin
         run_cycle();
      end
      ctrl_valid = 1'b0;
   endtask

   // ID read while every ID is taken
   // Grant must stay low throughout
   task automatic blocked_id_read(input int n);
      drive_req(1'b0, REG_CMD, 32'h0);
      repeat (n) run_cycle();
      ctrl_valid = 1'b0;
   endtask

   // Command word, local address and external address in a rotated order
   task automatic write_transfer(input int first);
      logic [1:0] order [3];
      order = '{REG_CMD, REG_TCDM, REG_EXT};
      for (int i = 0; i < 3; i++) begin
         reg_access(1'b1, order[(first + i) % 3], $urandom);
      end
   endtask

   initial begin
      rst_n      = 1'b0;
      ctrl_valid = 1'b0;
      ctrl_req   = '0;
      cmd_gnt    = 1'b0;
      done_valid = 1'b0;
      done_sid   = '0;
      exp_rvalid = 1'b0;
      exp_rdata  = '0;
      granted    = 1'b0;
      cycle_cnt  = 0;
      model_reset();
      void'($urandom(SEED));
      repeat (8) @(posedge clk);
      #2;
      rst_n = 1'b1;
      // Idle outputs straight after reset
      repeat (2) run_cycle();

      for (int t = 0; t < NB_TESTS; t++) begin
         if ($urandom % 3 == 0) begin
            reg_access(1'b0, REG_STATUS, 32'h0);
         end
         if (m_alloc == '1) begin
            blocked_id_read(1 + $urandom % 4);
            reg_access(1'b1, REG_STATUS, 32'(m_done) | (32'h1 << ($urandom % NB_TRANSFERS)));
         end else if ($urandom % 4 == 0) begin
            reg_access(1'b1, REG_STATUS, $urandom & 32'hF);
         end
         reg_access(1'b0, REG_CMD, 32'h0);
         write_transfer($urandom % 3);
      end

      // Drain the queues, then release every ID
      while (m_cmd_q.size() != 0 || m_tcdm_q.size() != 0 || m_ext_q.size() != 0) begin
         run_cycle();
      end
      reg_access(1'b1, REG_STATUS, 32'hF);
      reg_access(1'b0, REG_STATUS, 32'h0);
      repeat (3) run_cycle();
      check_value(busy, 1'b0, "busy_o after draining");

      $display("Simulation PASSED");
      $finish;
   end

endmodule

// File: dma_ctrl_top.f
+incdir+tb
hdl/dma_pkg.sv
hdl/dma_cmd_fifo.sv
hdl/dma_sid_alloc.sv
hdl/dma_reg_decoder.sv
hdl/dma_core_if.sv
hdl/dma_ctrl_top.sv
tb/dma_ctrl_tb.sv

// File: Makefile
# Verilator simulation of the DMA control front end

TOP = dma_ctrl_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f dma_ctrl_top.f
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir
